/* flist.f */
src/dtlb_pkg.sv
src/dtlb_plru_tree.sv
src/dtlb_req_decode.sv
src/dtlb_way_array.sv
src/dtlb_response.sv
src/dtlb_top.sv
testbench/tb_dtlb.sv

/* run.sh */
#!/bin/sh
# Build and run the DTLB testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dtlb -f flist.f -o sim_dtlb \
    && ./obj_dir/sim_dtlb | tee /dev/stderr | grep "STATUS: PASS" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* src/dtlb_pkg.sv */
package dtlb_pkg;

    // Geometry
    localparam int NUM_WAYS   = 16;
    localparam int NUM_SETS   = 8;
    localparam int TAG_WIDTH  = 20;
    localparam int SET_WIDTH  = 3;
    localparam int PPN_WIDTH  = 20;
    localparam int WAY_WIDTH  = 4;
    localparam int PLRU_NODES = 15;

    // Virtual page tag
    typedef logic [TAG_WIDTH-1:0] vpn_tag_t;

    typedef logic [SET_WIDTH-1:0] set_idx_t;

    // Physical page number
    typedef logic [PPN_WIDTH-1:0] ppn_t;

    typedef logic [WAY_WIDTH-1:0] way_idx_t;

    // One bit per way, hit vector or valid bits of a set
    typedef logic [NUM_WAYS-1:0] way_vec_t;

    // Tree-PLRU node bits, node 0 is the root
    typedef logic [PLRU_NODES-1:0] plru_bits_t;

    // Request from the load/store unit, ppn only used by fills
    typedef struct packed {
        logic     is_fill;
        vpn_tag_t tag;
        set_idx_t set;
        ppn_t     ppn;
    } dtlb_req_t;

    // Lookup response
    typedef struct packed {
        logic hit;
        ppn_t ppn;
    } dtlb_rsp_t;

    // Way used by a hit or a fill
    typedef struct packed {
        logic     valid;
        way_idx_t way;
    } plru_touch_t;

    // Request sequencer states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        EXEC    = 2'd1,
        RESPOND = 2'd2
    } req_state_e;

endpackage

/* src/dtlb_plru_tree.sv */
`timescale 1ns/1ps

module dtlb_plru_tree (
    input  logic                  clk,
    input  logic                  i_reset,
    input  dtlb_pkg::plru_touch_t i_touch,
    output dtlb_pkg::way_idx_t    o_victim
);

    dtlb_pkg::plru_bits_t bits_q;
    dtlb_pkg::plru_bits_t bits_d;

    // Walk from the root, bit 0 picks the lower half
    function automatic dtlb_pkg::way_idx_t walk_victim(input dtlb_pkg::plru_bits_t bits);
        int                 node;
        dtlb_pkg::way_idx_t way;
        node = 0;
        way  = '0;
        for (int lvl = 0; lvl < dtlb_pkg::WAY_WIDTH; lvl++) begin
            way[dtlb_pkg::WAY_WIDTH-1-lvl] = bits[node];
            node = 2 * node + 1 + int'(bits[node]);
        end
        return way;
    endfunction

    // Each node on the path points away from the touched way
    function automatic dtlb_pkg::plru_bits_t point_away(
        input dtlb_pkg::plru_bits_t bits,
        input dtlb_pkg::way_idx_t   way
    );
        int                   node;
        dtlb_pkg::plru_bits_t next;
        node = 0;
        next = bits;
        for (int lvl = 0; lvl < dtlb_pkg::WAY_WIDTH; lvl++) begin
            next[node] = !way[dtlb_pkg::WAY_WIDTH-1-lvl];
            node = 2 * node + 1 + int'(way[dtlb_pkg::WAY_WIDTH-1-lvl]);
        end
        return next;
    endfunction

    always_comb begin
        bits_d = bits_q;
        if (i_touch.valid) begin
            bits_d = point_away(bits_q, i_touch.way);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            bits_q <= '0;
        end else begin
            bits_q <= bits_d;
        end
    end

    assign o_victim = walk_victim(bits_q);

    // Just-touched way is never the next victim
    a_touch_protects: assert property (@(posedge clk) disable iff (i_reset)
        i_touch.valid |=> (o_victim != $past(i_touch.way)));

endmodule

/* src/dtlb_req_decode.sv */
`timescale 1ns/1ps

module dtlb_req_decode (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_req,
    input  dtlb_pkg::dtlb_req_t i_req_data,
    output logic                o_ack,
    output logic                o_lookup,
    output logic                o_fill,
    output dtlb_pkg::dtlb_req_t o_access
);

    dtlb_pkg::req_state_e state_q;
    dtlb_pkg::req_state_e state_d;
    dtlb_pkg::dtlb_req_t  access_q;
    logic                 ack_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dtlb_pkg::IDLE: begin
                if (i_req) begin
                    state_d = dtlb_pkg::EXEC;
                end
            end
            dtlb_pkg::EXEC: begin
                state_d = dtlb_pkg::RESPOND;
            end
            dtlb_pkg::RESPOND: begin
                // Requester drops req once it has seen ack
                if (!i_req) begin
                    state_d = dtlb_pkg::IDLE;
                end
            end
            default: begin
                state_d = dtlb_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= dtlb_pkg::IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Ack trails the state by one cycle on both edges
            ack_q   <= (state_q == dtlb_pkg::RESPOND);
        end
    end

    // Request payload held for the whole transaction
    always_ff @(posedge clk) begin
        if (state_q == dtlb_pkg::IDLE && i_req) begin
            access_q <= i_req_data;
        end
    end

    assign o_ack    = ack_q;
    assign o_access = access_q;
    assign o_lookup = (state_q == dtlb_pkg::EXEC) && !access_q.is_fill;
    assign o_fill   = (state_q == dtlb_pkg::EXEC) && access_q.is_fill;

    a_one_strobe: assert property (@(posedge clk) disable iff (i_reset)
        !(o_lookup && o_fill));

endmodule

/* src/dtlb_response.sv */
`timescale 1ns/1ps

module dtlb_response (
    input  logic                                    clk,
    input  logic                                    i_reset,
    input  logic                                    i_lookup,
    input  dtlb_pkg::way_vec_t                      i_hit_vec,
    input  dtlb_pkg::ppn_t [dtlb_pkg::NUM_WAYS-1:0] i_set_ppn,
    output dtlb_pkg::dtlb_rsp_t                     o_rsp
);

    dtlb_pkg::ppn_t hit_ppn;

    // AND-OR select, zero on a miss
    always_comb begin
        hit_ppn = '0;
        for (int w = 0; w < dtlb_pkg::NUM_WAYS; w++) begin
            hit_ppn = hit_ppn | (i_set_ppn[w] & {dtlb_pkg::PPN_WIDTH{i_hit_vec[w]}});
        end
    end

    // Fills leave the last lookup result in place
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rsp <= '0;
        end else if (i_lookup) begin
            o_rsp <= '{hit: |i_hit_vec, ppn: hit_ppn};
        end
    end

    // Relies on the array never holding a tag twice in one set
    a_hit_onehot: assert property (@(posedge clk) disable iff (i_reset)
        i_lookup |-> $onehot0(i_hit_vec));

endmodule

/* src/dtlb_top.sv */
`timescale 1ns/1ps

module dtlb_top (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_req,
    input  dtlb_pkg::dtlb_req_t i_req_data,
    output logic                o_ack,
    output dtlb_pkg::dtlb_rsp_t o_rsp
);

    logic                                    lookup;
    logic                                    fill;
    dtlb_pkg::dtlb_req_t                     access;
    dtlb_pkg::way_vec_t                      hit_vec;
    dtlb_pkg::ppn_t [dtlb_pkg::NUM_WAYS-1:0] set_ppn;

    dtlb_req_decode decode0 (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_req_data(i_req_data),
        .o_ack     (o_ack),
        .o_lookup  (lookup),
        .o_fill    (fill),
        .o_access  (access)
    );

    dtlb_way_array array0 (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_lookup (lookup),
        .i_fill   (fill),
        .i_access (access),
        .o_hit_vec(hit_vec),
        .o_set_ppn(set_ppn)
    );

    dtlb_response response0 (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_lookup (lookup),
        .i_hit_vec(hit_vec),
        .i_set_ppn(set_ppn),
        .o_rsp    (o_rsp)
    );

endmodule

/* src/dtlb_way_array.sv */
`timescale 1ns/1ps

module dtlb_way_array (
    input  logic                                    clk,
    input  logic                                    i_reset,
    input  logic                                    i_lookup,
    input  logic                                    i_fill,
    input  dtlb_pkg::dtlb_req_t                     i_access,
    output dtlb_pkg::way_vec_t                      o_hit_vec,
    output dtlb_pkg::ppn_t [dtlb_pkg::NUM_WAYS-1:0] o_set_ppn
);

    dtlb_pkg::way_vec_t    valid_q [dtlb_pkg::NUM_SETS];
    dtlb_pkg::vpn_tag_t    tag_q   [dtlb_pkg::NUM_SETS][dtlb_pkg::NUM_WAYS];
    dtlb_pkg::ppn_t        ppn_q   [dtlb_pkg::NUM_SETS][dtlb_pkg::NUM_WAYS];

    dtlb_pkg::way_vec_t    set_valid;
    dtlb_pkg::way_vec_t    tag_match;
    dtlb_pkg::way_idx_t    hit_way;
    dtlb_pkg::way_idx_t    free_way;
    dtlb_pkg::way_idx_t    fill_way;
    dtlb_pkg::way_idx_t    victim;
    dtlb_pkg::plru_touch_t touch;

    assign set_valid = valid_q[i_access.set];

    // Tag compare across all ways of the addressed set
    always_comb begin
        for (int w = 0; w < dtlb_pkg::NUM_WAYS; w++) begin
            tag_match[w] = set_valid[w] && (tag_q[i_access.set][w] == i_access.tag);
            o_set_ppn[w] = ppn_q[i_access.set][w];
        end
    end

    assign o_hit_vec = tag_match & {dtlb_pkg::NUM_WAYS{i_lookup}};

    // Hit vector is one-hot, so OR of the matching indices gives the way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dtlb_pkg::NUM_WAYS; w++) begin
            if (o_hit_vec[w]) begin
                hit_way = hit_way | dtlb_pkg::way_idx_t'(w);
            end
        end
    end

    // Scan from the top so the lowest free way is kept
    always_comb begin
        free_way = '0;
        for (int w = dtlb_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = dtlb_pkg::way_idx_t'(w);
            end
        end
    end

    // Full set falls back to the PLRU victim
    assign fill_way = (&set_valid) ? victim : free_way;

    assign touch = '{
        valid: i_fill || (|o_hit_vec),
        way:   i_fill ? fill_way : hit_way
    };

    dtlb_plru_tree plru0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_touch (touch),
        .o_victim(victim)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int s = 0; s < dtlb_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (i_fill) begin
            valid_q[i_access.set][fill_way] <= 1'b1;
        end
    end

    // Only the indexed set is written
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[i_access.set][fill_way] <= i_access.tag;
            ppn_q[i_access.set][fill_way] <= i_access.ppn;
        end
    end

    // Requester never fills a translation that is already present
    a_no_dup_fill: assert property (@(posedge clk) disable iff (i_reset)
        i_fill |-> (tag_match == '0));

    // A filled entry hits in the very next cycle
    a_fill_lands: assert property (@(posedge clk) disable iff (i_reset)
        i_fill |=> (tag_match != '0));

endmodule

/* testbench/dtlb_stimulus.txt */
# name  op  tag(hex)  set  ppn(hex)  exp_hit  exp_ppn(hex)
# op is L for lookup or F for fill, the last two columns of a fill row are not used
reset_miss_s0       L 12345 0 00000 0 00000
reset_miss_s3       L 0aaaa 3 00000 0 00000
reset_miss_s7       L fffff 7 00000 0 00000
fill_first          F 12345 2 abcde 0 00000
hit_first           L 12345 2 00000 1 abcde
miss_other_set      L 12345 5 00000 0 00000
fill_way01          F 20001 2 70001 0 00000
fill_way02          F 20002 2 70002 0 00000
fill_way03          F 20003 2 70003 0 00000
fill_way04          F 20004 2 70004 0 00000
fill_way05          F 20005 2 70005 0 00000
fill_way06          F 20006 2 70006 0 00000
fill_way07          F 20007 2 70007 0 00000
fill_way08          F 20008 2 70008 0 00000
fill_way09          F 20009 2 70009 0 00000
fill_way10          F 2000a 2 7000a 0 00000
fill_way11          F 2000b 2 7000b 0 00000
fill_way12          F 2000c 2 7000c 0 00000
fill_way13          F 2000d 2 7000d 0 00000
fill_way14          F 2000e 2 7000e 0 00000
fill_way15          F 2000f 2 7000f 0 00000
hit_way00           L 12345 2 00000 1 abcde
hit_way01           L 20001 2 00000 1 70001
hit_way02           L 20002 2 00000 1 70002
hit_way03           L 20003 2 00000 1 70003
hit_way04           L 20004 2 00000 1 70004
hit_way05           L 20005 2 00000 1 70005
hit_way06           L 20006 2 00000 1 70006
hit_way07           L 20007 2 00000 1 70007
hit_way08           L 20008 2 00000 1 70008
hit_way09           L 20009 2 00000 1 70009
hit_way10           L 2000a 2 00000 1 7000a
hit_way11           L 2000b 2 00000 1 7000b
hit_way12           L 2000c 2 00000 1 7000c
hit_way13           L 2000d 2 00000 1 7000d
hit_way14           L 2000e 2 00000 1 7000e
hit_way15           L 2000f 2 00000 1 7000f
fill_evict          F 30000 2 5a5a5 0 00000
miss_evicted        L 12345 2 00000 0 00000
hit_new             L 30000 2 00000 1 5a5a5
hit_victim_way08    L 20008 2 00000 1 70008
fill_after_touch    F 40000 2 6b6b6 0 00000
miss_evicted_way04  L 20004 2 00000 0 00000
hit_touched_way08   L 20008 2 00000 1 70008
hit_new_way04       L 40000 2 00000 1 6b6b6

/* testbench/tb_dtlb.sv */
`timescale 1ns/1ps

module tb_dtlb;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int MAX_WAIT    = 10;
    localparam int MAX_OPS     = 64;
    localparam int NAME_CHARS  = 24;
    localparam int LINE_CHARS  = 128;

    logic                clk;
    logic                i_reset;
    logic                i_req;
    dtlb_pkg::dtlb_req_t i_req_data;
    logic                o_ack;
    dtlb_pkg::dtlb_rsp_t o_rsp;

    // Operations read from the stimulus file
    logic [8*NAME_CHARS-1:0] op_name   [MAX_OPS];
    logic                    op_fill   [MAX_OPS];
    dtlb_pkg::vpn_tag_t      op_tag    [MAX_OPS];
    dtlb_pkg::set_idx_t      op_set    [MAX_OPS];
    dtlb_pkg::ppn_t          op_ppn    [MAX_OPS];
    dtlb_pkg::dtlb_rsp_t     op_expect [MAX_OPS];

    int                  num_ops;
    int                  pass_count;
    int                  fail_count;
    logic                loaded;
    logic                setup_error;
    dtlb_pkg::dtlb_rsp_t last_rsp;

    dtlb_top dut0 (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_req_data(i_req_data),
        .o_ack     (o_ack),
        .o_rsp     (o_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Rows that do not parse into all seven columns are comments
    task automatic load_stimulus();
        int                      fd;
        int                      fields;
        int                      set_num;
        int                      hit_num;
        logic [8*LINE_CHARS-1:0] line_buf;
        logic [8*NAME_CHARS-1:0] name;
        logic [7:0]              op;
        dtlb_pkg::vpn_tag_t      tag;
        dtlb_pkg::ppn_t          ppn;
        dtlb_pkg::ppn_t          exp_ppn;
        fd = $fopen("testbench/dtlb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR cannot open testbench/dtlb_stimulus.txt");
            setup_error = 1'b1;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                fields = $sscanf(line_buf, "%s %s %h %d %h %d %h",
                                 name, op, tag, set_num, ppn, hit_num, exp_ppn);
                if (fields == 7 && (op == "L" || op == "F")) begin
                    if (num_ops == MAX_OPS) begin
                        $display("ERROR stimulus file holds more than %0d operations", MAX_OPS);
                        setup_error = 1'b1;
                        break;
                    end
                    op_name[num_ops]       = name;
                    op_fill[num_ops]       = (op == "F");
                    op_tag[num_ops]        = tag;
                    op_set[num_ops]        = dtlb_pkg::set_idx_t'(set_num);
                    op_ppn[num_ops]        = ppn;
                    op_expect[num_ops].hit = (hit_num != 0);
                    op_expect[num_ops].ppn = exp_ppn;
                    num_ops++;
                end
            end
            $fclose(fd);
            if (num_ops == 0) begin
                $display("ERROR stimulus file holds no operations");
                setup_error = 1'b1;
            end
        end
    endtask

    // One full four-phase transaction, called just after a rising edge
    task automatic run_op(input int idx);
        int                  waited;
        logic                ok;
        dtlb_pkg::dtlb_rsp_t expect_rsp;
        ok = 1'b1;
        // A fill leaves the last lookup result on o_rsp
        expect_rsp = op_fill[idx] ? last_rsp : op_expect[idx];
        if (o_ack !== 1'b0) begin
            $display("ERROR %0s: ack is high before the request was raised", op_name[idx]);
            ok = 1'b0;
        end
        i_req_data.is_fill = op_fill[idx];
        i_req_data.tag     = op_tag[idx];
        i_req_data.set     = op_set[idx];
        i_req_data.ppn     = op_ppn[idx];
        i_req              = 1'b1;
        waited = 0;
        while (o_ack !== 1'b1 && waited < MAX_WAIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (o_ack !== 1'b1) begin
            $display("ERROR %0s: no ack within %0d cycles of the request",
                     op_name[idx], MAX_WAIT);
            ok = 1'b0;
        end else if (o_rsp !== expect_rsp) begin
            $display("ERROR %0s: expected hit=%0b ppn=%h, actual hit=%0b ppn=%h",
                     op_name[idx], expect_rsp.hit, expect_rsp.ppn, o_rsp.hit, o_rsp.ppn);
            ok = 1'b0;
        end
        i_req = 1'b0;
        waited = 0;
        while (o_ack !== 1'b0 && waited < MAX_WAIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (o_ack !== 1'b0) begin
            $display("ERROR %0s: ack did not fall within %0d cycles after req dropped",
                     op_name[idx], MAX_WAIT);
            ok = 1'b0;
        end
        last_rsp = expect_rsp;
        if (ok) begin
            pass_count++;
            $display("test %0s passed", op_name[idx]);
        end else begin
            fail_count++;
            $display("test %0s failed", op_name[idx]);
        end
    endtask

    initial begin
        i_reset     = 1'b1;
        i_req       = 1'b0;
        i_req_data  = '0;
        num_ops     = 0;
        pass_count  = 0;
        fail_count  = 0;
        loaded      = 1'b0;
        setup_error = 1'b0;
        last_rsp    = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !setup_error) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Each transaction needs about five cycles
    initial begin
        wait (loaded);
        #((num_ops * 10 + 20) * CLK_PERIOD);
        $display("ERROR watchdog expired, the run did not finish within %0d cycles",
                 num_ops * 10 + 20);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
